//--- build.f
+incdir+.
mm_pkg.sv
mem_bus_if.sv
dp_ram.sv
data_router.sv
vp_status.sv
vp_event_gen.sv
mm_ram.sv
tb_mm_ram.sv

//--- data_router.sv
// ------------------------------
// Data bus decoder between RAM and
// the virtual peripherals
// ------------------------------
`timescale 1ns/1ps
`include "mm_defines.svh"

module data_router
    import mm_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    mem_bus_if.slave  core_bus,
    mem_bus_if.master ram_bus,
    output logic      vp_we_o,
    output addr_t     vp_addr_o,
    output data_t     vp_wdata_o
);

    logic is_periph;
    logic core_accept;
    logic rvalid_q;
    logic ram_sel_q;

    // Peripheral space starts at a fixed base
    assign is_periph = (core_bus.addr >= `MM_PERIPH_BASE);

    // ------------------------------
    // Request path
    // ------------------------------
    assign ram_bus.req   = core_bus.req & ~is_periph;
    assign ram_bus.addr  = core_bus.addr;
    assign ram_bus.we    = core_bus.we;
    assign ram_bus.be    = core_bus.be;
    assign ram_bus.wdata = core_bus.wdata;

    // Peripherals never stall, RAM grants on its own
    assign core_bus.gnt = is_periph ? core_bus.req : ram_bus.gnt;
    assign core_accept  = core_bus.req & core_bus.gnt;

    // Single-cycle write strobe towards the peripherals
    assign vp_we_o    = core_accept & is_periph & core_bus.we;
    assign vp_addr_o  = {core_bus.addr[31:2], 2'b00};
    assign vp_wdata_o = core_bus.wdata;

    // ------------------------------
    // Response path
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q  <= 1'b0;
            ram_sel_q <= 1'b0;
        end else begin
            rvalid_q  <= core_accept;
            ram_sel_q <= core_accept & ~is_periph;
        end
    end

    assign core_bus.rvalid = rvalid_q;

    // Peripheral reads give zero
    assign core_bus.rdata = (ram_sel_q && ram_bus.rvalid) ? ram_bus.rdata : '0;

endmodule

//--- dp_ram.sv
// ------------------------------
// Dual-port byte RAM with a read-only
// instruction port and a read/write data port
// ------------------------------
`timescale 1ns/1ps
`include "mm_defines.svh"

module dp_ram
    import mm_pkg::*;
#(
    parameter int ADDR_WIDTH = `MM_RAM_ADDR_WIDTH
) (
    input  logic     clk_i,
    mem_bus_if.slave instr_bus,
    mem_bus_if.slave data_bus
);

    localparam int NUM_BYTES = 2 ** ADDR_WIDTH;

    byte_t mem [NUM_BYTES];

    logic [ADDR_WIDTH-1:0] instr_base;
    logic [ADDR_WIDTH-1:0] data_base;
    logic                  instr_accept;
    logic                  data_accept;
    logic                  instr_rvalid_q;
    logic                  data_rvalid_q;
    data_t                 instr_rdata_q;
    data_t                 data_rdata_q;

    // Word-aligned byte index, upper address bits dropped
    assign instr_base = {instr_bus.addr[ADDR_WIDTH-1:2], 2'b00};
    assign data_base  = {data_bus.addr[ADDR_WIDTH-1:2], 2'b00};

    // Both ports accept every request
    assign instr_bus.gnt = instr_bus.req;
    assign data_bus.gnt  = data_bus.req;

    assign instr_accept = instr_bus.req & instr_bus.gnt;
    assign data_accept  = data_bus.req & data_bus.gnt;

    // ------------------------------
    // Instruction port
    // ------------------------------
    always_ff @(posedge clk_i) begin
        instr_rvalid_q <= instr_accept;
        if (instr_accept) begin
            for (int i = 0; i < 4; i++) begin
                instr_rdata_q[8*i +: 8] <= mem[instr_base + i];
            end
        end
    end

    assign instr_bus.rvalid = instr_rvalid_q;
    assign instr_bus.rdata  = instr_rdata_q;

    // ------------------------------
    // Data port
    // ------------------------------
    // Writes land at the edge, so a same-cycle fetch still sees the old word
    always_ff @(posedge clk_i) begin
        data_rvalid_q <= data_accept;
        if (data_accept && data_bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (data_bus.be[i]) begin
                    mem[data_base + i] <= data_bus.wdata[8*i +: 8];
                end
            end
        end else if (data_accept) begin
            for (int i = 0; i < 4; i++) begin
                data_rdata_q[8*i +: 8] <= mem[data_base + i];
            end
        end
    end

    assign data_bus.rvalid = data_rvalid_q;
    assign data_bus.rdata  = data_rdata_q;

endmodule

//--- mem_bus_if.sv
// ------------------------------
// One req/gnt/rvalid request bus
// ------------------------------
`timescale 1ns/1ps

interface mem_bus_if
    import mm_pkg::*;
();

    // Request side
    logic  req;
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;

    // Response side
    logic  gnt;
    logic  rvalid;
    data_t rdata;

    modport master (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport slave (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

//--- mm_defines.svh
// ------------------------------
// Address map, RAM size, test magic values
// and interrupt count of the memory model
// ------------------------------
`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// Byte-address bits of the RAM
`define MM_RAM_ADDR_WIDTH 16

// Everything at or above this address is peripheral space
`define MM_PERIPH_BASE 32'h1000_0000

// Virtual peripheral registers
`define MM_PRINT_ADDR       32'h1000_0000
`define MM_TIMER_VALUE_ADDR 32'h1500_0000
`define MM_TIMER_ID_ADDR    32'h1500_0004
`define MM_DEBUG_ADDR       32'h1580_0000
`define MM_STATUS_ADDR      32'h2000_0000
`define MM_EXIT_ADDR        32'h2000_0004

// Values written to the status register
`define MM_TEST_PASS_VALUE 32'd123456789
`define MM_TEST_FAIL_VALUE 32'd1

`define MM_IRQ_COUNT 32

`endif

//--- mm_pkg.sv
// ------------------------------
// Bus, memory and interrupt types
// plus the interrupt timer states
// ------------------------------
`include "mm_defines.svh"

package mm_pkg;

    // Bus address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // One enable per byte lane
    typedef logic [3:0] be_t;

    // Memory byte, also used for print characters
    typedef logic [7:0] byte_t;

    // Interrupt lines and the index of one line
    typedef logic [`MM_IRQ_COUNT-1:0]         irq_vec_t;
    typedef logic [$clog2(`MM_IRQ_COUNT)-1:0] irq_id_t;

    // Interrupt timer
    typedef enum logic [1:0] {
        TMR_IDLE,
        TMR_COUNT,
        TMR_PENDING
    } timer_state_e;

endpackage

//--- mm_ram.sv
// ------------------------------
// Memory-mapped RAM with virtual peripherals
// ------------------------------
`timescale 1ns/1ps

module mm_ram
    import mm_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,

    // Instruction fetch bus
    input  logic     instr_req_i,
    input  addr_t    instr_addr_i,
    output logic     instr_gnt_o,
    output logic     instr_rvalid_o,
    output data_t    instr_rdata_o,

    // Data bus
    input  logic     data_req_i,
    input  addr_t    data_addr_i,
    input  logic     data_we_i,
    input  be_t      data_be_i,
    input  data_t    data_wdata_i,
    output logic     data_gnt_o,
    output logic     data_rvalid_o,
    output data_t    data_rdata_o,

    // Interrupts
    input  logic     irq_ack_i,
    input  irq_id_t  irq_id_i,
    output irq_vec_t irq_o,

    // Debug and test status
    output logic     debug_req_o,
    output logic     print_valid_o,
    output byte_t    print_char_o,
    output logic     tests_passed_o,
    output logic     tests_failed_o,
    output logic     exit_valid_o,
    output data_t    exit_value_o
);

    mem_bus_if instr_bus ();
    mem_bus_if core_data_bus ();
    mem_bus_if ram_data_bus ();

    logic  vp_we;
    addr_t vp_addr;
    data_t vp_wdata;

    // ------------------------------
    // Port mapping
    // ------------------------------
    // Fetch port never writes
    assign instr_bus.req   = instr_req_i;
    assign instr_bus.addr  = instr_addr_i;
    assign instr_bus.we    = 1'b0;
    assign instr_bus.be    = '0;
    assign instr_bus.wdata = '0;
    assign instr_gnt_o     = instr_bus.gnt;
    assign instr_rvalid_o  = instr_bus.rvalid;
    assign instr_rdata_o   = instr_bus.rdata;

    assign core_data_bus.req   = data_req_i;
    assign core_data_bus.addr  = data_addr_i;
    assign core_data_bus.we    = data_we_i;
    assign core_data_bus.be    = data_be_i;
    assign core_data_bus.wdata = data_wdata_i;
    assign data_gnt_o          = core_data_bus.gnt;
    assign data_rvalid_o       = core_data_bus.rvalid;
    assign data_rdata_o        = core_data_bus.rdata;

    // ------------------------------
    // Instances
    // ------------------------------
    data_router u_data_router (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .core_bus   (core_data_bus.slave),
        .ram_bus    (ram_data_bus.master),
        .vp_we_o    (vp_we),
        .vp_addr_o  (vp_addr),
        .vp_wdata_o (vp_wdata)
    );

    dp_ram u_dp_ram (
        .clk_i     (clk_i),
        .instr_bus (instr_bus.slave),
        .data_bus  (ram_data_bus.slave)
    );

    vp_status u_vp_status (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .vp_we_i        (vp_we),
        .vp_addr_i      (vp_addr),
        .vp_wdata_i     (vp_wdata),
        .print_valid_o  (print_valid_o),
        .print_char_o   (print_char_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    vp_event_gen u_vp_event_gen (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .vp_we_i     (vp_we),
        .vp_addr_i   (vp_addr),
        .vp_wdata_i  (vp_wdata),
        .irq_ack_i   (irq_ack_i),
        .irq_id_i    (irq_id_i),
        .irq_o       (irq_o),
        .debug_req_o (debug_req_o)
    );

endmodule

//--- tb_mm_ram.sv
// ------------------------------
// Testbench for mm_ram acting as the core,
// with a RAM model, scoreboards and assertions
// ------------------------------
`timescale 1ns/1ps
`include "mm_defines.svh"

module tb_mm_ram
    import mm_pkg::*;
();

    // About 150 cycles of traffic, generous margin on top
    localparam int MAX_CYCLES = 2000;

    logic     clk_i = 1'b0;
    logic     arst_n_i;
    logic     instr_req_i, instr_gnt_o, instr_rvalid_o;
    addr_t    instr_addr_i;
    data_t    instr_rdata_o;
    logic     data_req_i, data_we_i, data_gnt_o, data_rvalid_o;
    addr_t    data_addr_i;
    be_t      data_be_i;
    data_t    data_wdata_i, data_rdata_o;
    logic     irq_ack_i;
    irq_id_t  irq_id_i;
    irq_vec_t irq_o;
    logic     debug_req_o, print_valid_o, tests_passed_o, tests_failed_o, exit_valid_o;
    byte_t    print_char_o;
    data_t    exit_value_o;

    byte_t       ref_mem [2 ** `MM_RAM_ADDR_WIDTH];
    logic [32:0] data_sb [$];
    data_t       instr_sb [$];
    logic [32:0] data_exp = '0;
    data_t       instr_exp = '0;
    addr_t       words [16];
    int          seed = 67;
    int          errors = 0;
    int          reads_checked = 0;
    int          fetches_checked = 0;
    int          cycles = 0;

    // Expected peripheral state
    logic    pass_seen, fail_seen, exit_seen, tmr_armed;
    data_t   tmr_wait;
    irq_id_t tmr_sel;
    logic    periph_wr, print_wr, exit_wr, debug_wr;

    mm_ram DUT (.*);

    always #4 clk_i = ~clk_i;

    assign periph_wr = data_req_i && data_gnt_o && data_we_i && (data_addr_i >= `MM_PERIPH_BASE);
    assign print_wr  = periph_wr && (data_addr_i == `MM_PRINT_ADDR);
    assign exit_wr   = periph_wr && (data_addr_i == `MM_EXIT_ADDR);
    assign debug_wr  = periph_wr && (data_addr_i == `MM_DEBUG_ADDR);

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    function automatic data_t model_word(input addr_t addr);
        int base;
        base = {addr[`MM_RAM_ADDR_WIDTH-1:2], 2'b00};
        return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
    endfunction

    task automatic model_write(input addr_t addr, input be_t be, input data_t wdata);
        int base;
        base = {addr[`MM_RAM_ADDR_WIDTH-1:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                ref_mem[base+i] = wdata[8*i +: 8];
            end
        end
    endtask

    // ------------------------------
    // Scoreboards and reference models
    // ------------------------------
    always @(posedge clk_i) begin
        if (arst_n_i) begin
            if (instr_rvalid_o && instr_sb.size() > 0) begin
                void'(instr_sb.pop_front());
                fetches_checked++;
            end
            if (data_rvalid_o && data_sb.size() > 0) begin
                reads_checked += data_sb.pop_front() >> 32;
            end
            // Fetch sees the word before a same-cycle data write
            if (instr_req_i && instr_gnt_o) begin
                instr_sb.push_back(model_word(instr_addr_i));
            end
            if (data_req_i && data_gnt_o) begin
                if (data_we_i) begin
                    data_sb.push_back({1'b0, 32'h0});
                    if (data_addr_i < `MM_PERIPH_BASE) begin
                        model_write(data_addr_i, data_be_i, data_wdata_i);
                    end
                end else if (data_addr_i >= `MM_PERIPH_BASE) begin
                    data_sb.push_back({1'b1, 32'h0});
                end else begin
                    data_sb.push_back({1'b1, model_word(data_addr_i)});
                end
            end
            instr_exp <= (instr_sb.size() > 0) ? instr_sb[0] : '0;
            data_exp  <= (data_sb.size() > 0) ? data_sb[0] : '0;
        end
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pass_seen <= 1'b0;
            fail_seen <= 1'b0;
            exit_seen <= 1'b0;
            tmr_armed <= 1'b0;
            tmr_wait  <= '0;
            tmr_sel   <= '0;
        end else begin
            if (periph_wr && data_addr_i == `MM_STATUS_ADDR) begin
                pass_seen <= pass_seen | (data_wdata_i == `MM_TEST_PASS_VALUE);
                fail_seen <= fail_seen | (data_wdata_i == `MM_TEST_FAIL_VALUE);
            end
            exit_seen <= exit_seen | exit_wr;
            if (periph_wr && data_addr_i == `MM_TIMER_ID_ADDR) begin
                tmr_sel <= data_wdata_i[$bits(irq_id_t)-1:0];
            end
            // Count N shows the irq N+1 edges after the write
            if (periph_wr && data_addr_i == `MM_TIMER_VALUE_ADDR) begin
                tmr_armed <= 1'b1;
                tmr_wait  <= data_wdata_i;
            end else if (tmr_armed && tmr_wait != 0) begin
                tmr_wait <= tmr_wait - 1;
            end else if (tmr_armed && irq_ack_i && irq_id_i == tmr_sel) begin
                tmr_armed <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    a_reset: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !(instr_rvalid_o
        || data_rvalid_o || print_valid_o || tests_passed_o || tests_failed_o
        || exit_valid_o || debug_req_o || irq_o != '0))
        else report_error("control outputs active after reset");
    a_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_gnt_o === instr_req_i && data_gnt_o === data_req_i)
        else report_error("gnt differs from req");
    a_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_rvalid_o === $past(instr_req_i && instr_gnt_o)
        && data_rvalid_o === $past(data_req_i && data_gnt_o))
        else report_error("rvalid not one cycle after acceptance");
    a_instr_rdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_rvalid_o |-> instr_rdata_o === instr_exp)
        else report_error($sformatf("fetch data %h, expected %h", instr_rdata_o, instr_exp));
    a_data_rdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_rvalid_o && data_exp[32] |-> data_rdata_o === data_exp[31:0])
        else report_error($sformatf("read data %h, expected %h", data_rdata_o, data_exp[31:0]));
    a_print: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        print_wr |=> print_valid_o && print_char_o === $past(data_wdata_i[7:0]))
        else report_error("print strobe or character wrong");
    a_print_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !print_wr |=> !print_valid_o)
        else report_error("print strobe without a print write");
    a_status: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tests_passed_o === pass_seen && tests_failed_o === fail_seen)
        else report_error("test status flags wrong");
    a_exit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        exit_wr |=> exit_valid_o && exit_value_o === $past(data_wdata_i))
        else report_error("exit strobe or value wrong");
    a_exit_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !exit_wr |=> !exit_valid_o)
        else report_error("exit strobe without an exit write");
    a_exit_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        exit_seen && !exit_wr |=> $stable(exit_value_o))
        else report_error("exit value not held");
    a_irq: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        irq_o === ((tmr_armed && tmr_wait == 0) ? (irq_vec_t'(1) << tmr_sel) : irq_vec_t'(0)))
        else report_error($sformatf("irq_o is %h", irq_o));
    a_debug: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        debug_wr |=> debug_req_o === $past(data_wdata_i[0]))
        else report_error("debug request does not follow the write");
    a_debug_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !debug_wr |=> $stable(debug_req_o))
        else report_error("debug request changed without a write");

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic data_access(input addr_t addr, input logic we, input be_t be,
                               input data_t wdata);
        data_req_i   = 1'b1;
        data_addr_i  = addr;
        data_we_i    = we;
        data_be_i    = be;
        data_wdata_i = wdata;
        @(posedge clk_i);
        while (!data_gnt_o) @(posedge clk_i);
        #1;
        data_req_i = 1'b0;
    endtask

    task automatic fetch_words();
        for (int i = 0; i < 16; i++) begin
            instr_req_i  = 1'b1;
            instr_addr_i = words[i];
            @(posedge clk_i);
            while (!instr_gnt_o) @(posedge clk_i);
            #1;
        end
        instr_req_i = 1'b0;
    endtask

    task automatic timer_round(input irq_id_t id, input data_t count);
        data_access(`MM_TIMER_ID_ADDR, 1'b1, 4'hF, data_t'(id));
        data_access(`MM_TIMER_VALUE_ADDR, 1'b1, 4'hF, count);
        while (irq_o == '0) @(posedge clk_i);
        #1;
        repeat (2) @(posedge clk_i);
        #1;
        // Wrong id first, then the selected one
        irq_ack_i = 1'b1;
        irq_id_i  = id + 1'b1;
        @(posedge clk_i);
        #1;
        irq_id_i = id;
        @(posedge clk_i);
        #1;
        irq_ack_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        arst_n_i     = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_ack_i    = 1'b0;
        irq_id_i     = '0;
        repeat (2) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        // Full words first so that every later read hits known bytes
        for (int i = 0; i < 16; i++) begin
            words[i] = addr_t'($random(seed)) & 32'h0FFF_FFFC;
            data_access(words[i], 1'b1, 4'hF, $random(seed));
        end
        for (int i = 0; i < 16; i++) begin
            data_access(words[$random(seed) & 15], 1'b1, be_t'($random(seed)), $random(seed));
        end
        // Fetches in parallel, odd slots write the word being fetched
        fork
            fetch_words();
            for (int i = 0; i < 16; i++) begin
                data_access(words[i], i[0], be_t'($random(seed)), $random(seed));
            end
        join
        for (int i = 0; i < 16; i++) begin
            data_access(words[i], 1'b0, 4'hF, '0);
        end

        data_access(`MM_STATUS_ADDR, 1'b0, 4'hF, '0);
        data_access(`MM_TIMER_ID_ADDR, 1'b0, 4'hF, '0);
        for (int i = 0; i < 4; i++) begin
            data_access(`MM_PRINT_ADDR, 1'b1, 4'hF, $random(seed));
        end
        data_access(`MM_STATUS_ADDR, 1'b1, 4'hF, `MM_TEST_PASS_VALUE);
        data_access(`MM_EXIT_ADDR, 1'b1, 4'hF, $random(seed));
        repeat (3) @(posedge clk_i);
        #1;
        data_access(`MM_STATUS_ADDR, 1'b1, 4'hF, `MM_TEST_FAIL_VALUE);
        data_access(`MM_DEBUG_ADDR, 1'b1, 4'hF, 32'h1);
        data_access(`MM_DEBUG_ADDR, 1'b1, 4'hF, 32'h2);
        data_access(`MM_DEBUG_ADDR, 1'b1, 4'hF, 32'h3);

        timer_round(irq_id_t'(7), 32'd0);
        timer_round(irq_id_t'($random(seed)), data_t'($random(seed) & 15) + 32'd1);
        repeat (3) @(posedge clk_i);

        $display("errors: %0d, data reads checked: %0d, fetches checked: %0d",
                 errors, reads_checked, fetches_checked);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- vp_event_gen.sv
// ------------------------------
// Interrupt timer and debug request register
// ------------------------------
`timescale 1ns/1ps
`include "mm_defines.svh"

module vp_event_gen
    import mm_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     vp_we_i,
    input  addr_t    vp_addr_i,
    input  data_t    vp_wdata_i,
    input  logic     irq_ack_i,
    input  irq_id_t  irq_id_i,
    output irq_vec_t irq_o,
    output logic     debug_req_o
);

    timer_state_e state_q;
    timer_state_e state_d;
    data_t        count_q;
    data_t        count_d;
    irq_id_t      irq_sel_q;
    logic         value_hit;
    logic         id_hit;
    logic         debug_hit;
    logic         ack_match;

    assign value_hit = vp_we_i && (vp_addr_i == `MM_TIMER_VALUE_ADDR);
    assign id_hit    = vp_we_i && (vp_addr_i == `MM_TIMER_ID_ADDR);
    assign debug_hit = vp_we_i && (vp_addr_i == `MM_DEBUG_ADDR);
    assign ack_match = irq_ack_i && (irq_id_i == irq_sel_q);

    // ------------------------------
    // Timer FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        count_d = count_q;
        if (value_hit) begin
            // A fresh count restarts the timer and drops a pending irq
            count_d = vp_wdata_i;
            state_d = (vp_wdata_i == '0) ? TMR_PENDING : TMR_COUNT;
        end else begin
            case (state_q)
                TMR_COUNT: begin
                    count_d = count_q - 32'd1;
                    if (count_q <= 32'd1) begin
                        state_d = TMR_PENDING;
                    end
                end
                TMR_PENDING: begin
                    if (ack_match) begin
                        state_d = TMR_IDLE;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= TMR_IDLE;
            count_q     <= '0;
            irq_sel_q   <= '0;
            debug_req_o <= 1'b0;
        end else begin
            state_q <= state_d;
            count_q <= count_d;
            if (id_hit) begin
                irq_sel_q <= vp_wdata_i[$bits(irq_id_t)-1:0];
            end
            // Debug request level
            if (debug_hit) begin
                debug_req_o <= vp_wdata_i[0];
            end
        end
    end

    // One-hot line while pending
    assign irq_o = (state_q == TMR_PENDING) ? (irq_vec_t'(1) << irq_sel_q) : '0;

endmodule

//--- vp_status.sv
// ------------------------------
// Print port, test status flags and exit
// ------------------------------
`timescale 1ns/1ps
`include "mm_defines.svh"

module vp_status
    import mm_pkg::*;
(
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  vp_we_i,
    input  addr_t vp_addr_i,
    input  data_t vp_wdata_i,
    output logic  print_valid_o,
    output byte_t print_char_o,
    output logic  tests_passed_o,
    output logic  tests_failed_o,
    output logic  exit_valid_o,
    output data_t exit_value_o
);

    logic print_hit;
    logic status_hit;
    logic exit_hit;

    assign print_hit  = vp_we_i && (vp_addr_i == `MM_PRINT_ADDR);
    assign status_hit = vp_we_i && (vp_addr_i == `MM_STATUS_ADDR);
    assign exit_hit   = vp_we_i && (vp_addr_i == `MM_EXIT_ADDR);

    // Strobes and sticky flags
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            print_valid_o  <= 1'b0;
            exit_valid_o   <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
        end else begin
            print_valid_o <= print_hit;
            exit_valid_o  <= exit_hit;
            if (status_hit && (vp_wdata_i == `MM_TEST_PASS_VALUE)) begin
                tests_passed_o <= 1'b1;
            end
            if (status_hit && (vp_wdata_i == `MM_TEST_FAIL_VALUE)) begin
                tests_failed_o <= 1'b1;
            end
        end
    end

    // Character and exit code
    always_ff @(posedge clk_i) begin
        if (print_hit) begin
            print_char_o <= vp_wdata_i[7:0];
        end
        if (exit_hit) begin
            exit_value_o <= vp_wdata_i;
        end
    end

endmodule
